/* ibus_pkg.sv */
// ----------------------------------------------------------------------
// instruction bus types, req/gnt/rvalid protocol
// master holds req and addr stable until gnt, one rvalid per grant
// fetch is word-aligned only, no byte enables on this bus
// ----------------------------------------------------------------------
package ibus_pkg;

  // ----------------------------------------------------------------------
  // request and response sides
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic        req;   // held until granted
    logic [31:0] addr;  // word-aligned
  } ibus_req_t;

  typedef struct packed {
    logic        gnt;     // request accepted this cycle
    logic        rvalid;  // rdata valid, one per grant
    logic [31:0] rdata;
  } ibus_rsp_t;

  // address step of one fetch
  localparam logic [31:0] WORD_BYTES = 32'd4;

endpackage

/* if_ctrl_pkg.sv */
// ----------------------------------------------------------------------
// fetch control definitions shared by the pc selector, the issue logic
// and the controller that drives redirects into the fetch stage
// redirect_t packs to 11 bits and if_id_t to 65 bits, with msb first
// ----------------------------------------------------------------------
package if_ctrl_pkg;

  // ----------------------------------------------------------------------
  // selector enums
  // ----------------------------------------------------------------------

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,  // boot address plus reset offset
    PC_JUMP      = 3'd1,  // jump resolved in id
    PC_BRANCH    = 3'd2,  // branch resolved in ex
    PC_EXCEPTION = 3'd3,  // trap vector, see exc_pc_mux_e
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6   // refetch after the instruction in id
  } pc_mux_e;

  // which kind of trap target
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,  // vectored by exc_vec
    EXC_PC_DBD       = 2'd2,  // debug halt
    EXC_PC_DBE       = 2'd3   // debug exception
  } exc_pc_mux_e;

  // ----------------------------------------------------------------------
  // records
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic        pc_set;      // one-cycle strobe, take the redirect
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    logic [4:0]  exc_vec;     // interrupt line for vectored mode
  } redirect_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_t;

  // low byte appended to boot_addr on reset
  localparam logic [7:0] RST_OFFSET = 8'h80;

endpackage

/* if_pc_select.sv */
// ----------------------------------------------------------------------
// next fetch address mux, purely combinational
// trap base is the upper 24 bits of mtvec, vectored irq uses 4-byte slots
// output is always forced to a word boundary
// ----------------------------------------------------------------------
module if_pc_select #(
  parameter logic [31:0] DM_HALT_ADDR = 32'h1A11_0800,
  parameter logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808
) (
  input  logic [23:0]            boot_addr_i,
  input  logic [23:0]            trap_base_i,
  input  if_ctrl_pkg::redirect_t redirect_i,
  input  logic [31:0]            jump_target_id_i,
  input  logic [31:0]            jump_target_ex_i,
  input  logic [31:0]            mepc_i,
  input  logic [31:0]            depc_i,
  input  logic [31:0]            pc_id_i,           // pc of record held in id
  output logic [31:0]            fetch_addr_o
);

  logic [31:0] exc_pc;        // trap / debug target
  logic [31:0] fetch_addr_n;  // before alignment

  // ----------------------------------------------------------------------
  // exception vector
  // ----------------------------------------------------------------------
  always_comb begin
    exc_pc = DM_HALT_ADDR;
    unique case (redirect_i.exc_pc_mux)
      if_ctrl_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base_i, 8'h00};  // all sync traps at base
      if_ctrl_pkg::EXC_PC_IRQ:       exc_pc = {trap_base_i, 1'b0, redirect_i.exc_vec, 2'b00};
      if_ctrl_pkg::EXC_PC_DBD:       exc_pc = DM_HALT_ADDR;
      if_ctrl_pkg::EXC_PC_DBE:       exc_pc = DM_EXC_ADDR;
      default:                       exc_pc = DM_HALT_ADDR;
    endcase
  end

  // ----------------------------------------------------------------------
  // fetch address
  // ----------------------------------------------------------------------
  always_comb begin
    fetch_addr_n = {boot_addr_i, if_ctrl_pkg::RST_OFFSET};
    unique case (redirect_i.pc_mux)
      if_ctrl_pkg::PC_BOOT:      fetch_addr_n = {boot_addr_i, if_ctrl_pkg::RST_OFFSET};
      if_ctrl_pkg::PC_JUMP:      fetch_addr_n = jump_target_id_i;
      if_ctrl_pkg::PC_BRANCH:    fetch_addr_n = jump_target_ex_i;
      if_ctrl_pkg::PC_EXCEPTION: fetch_addr_n = exc_pc;
      if_ctrl_pkg::PC_MRET:      fetch_addr_n = mepc_i;   // back from trap handler
      if_ctrl_pkg::PC_DRET:      fetch_addr_n = depc_i;   // back from debug mode
      // refetch the word after the one in id so the prefetch fifo reloads
      if_ctrl_pkg::PC_FENCEI:    fetch_addr_n = pc_id_i + ibus_pkg::WORD_BYTES;
      default:                   fetch_addr_n = {boot_addr_i, if_ctrl_pkg::RST_OFFSET};
    endcase
  end

  // word fetch only, low bits dropped
  assign fetch_addr_o = {fetch_addr_n[31:2], 2'b00};

endmodule

/* if_prefetch.sv */
// ----------------------------------------------------------------------
// instruction bus master with one request in flight and a word fifo
// fetching starts at the first branch_i after reset and stops on req_i low
// a flush empties the fifo at once, a late stale response is dropped
// FIFO_DEPTH >= 2, any value
// ----------------------------------------------------------------------
module if_prefetch #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,       // fetch enable
  input  logic                branch_i,    // flush and restart at addr_i
  input  logic [31:0]         addr_i,
  input  logic                ready_i,     // head word consumed
  output logic                valid_o,
  output logic [31:0]         rdata_o,
  output logic [31:0]         addr_o,
  output logic                busy_o,
  output ibus_pkg::ibus_req_t ibus_req_o,
  input  ibus_pkg::ibus_rsp_t ibus_rsp_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } entry_t;

  entry_t            fifo_mem [FIFO_DEPTH];  // payload only, no reset
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [CNT_W:0]    fill;                   // entries plus request in flight

  logic              req_q;          // req raised on the bus
  logic              outstanding_q;  // granted, waiting for rvalid
  logic              discard_q;      // pending response is stale
  logic              active_q;       // a start address has been given
  logic [31:0]       addr_q;         // address on the bus
  logic [31:0]       next_addr_q;    // address of the following request

  logic              gnt_take, resp_done, fifo_wr, fifo_rd;
  logic              bus_free, room, issue;
  logic [31:0]       issue_addr;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ----------------------------------------------------------------------
  // bus side
  // ----------------------------------------------------------------------
  assign gnt_take  = req_q & ibus_rsp_i.gnt;
  assign resp_done = outstanding_q & ibus_rsp_i.rvalid;
  assign bus_free  = ~req_q & (~outstanding_q | ibus_rsp_i.rvalid);  // free after this edge

  assign fill = {1'b0, count_q} + (CNT_W + 1)'(outstanding_q);
  assign room = fill < (CNT_W + 1)'(FIFO_DEPTH);  // back-pressure

  // on a flush the fifo is empty after this edge, so room is guaranteed
  assign issue      = req_i & bus_free & (branch_i | (active_q & room));
  assign issue_addr = branch_i ? addr_i : next_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      active_q      <= 1'b0;
    end else begin
      if (branch_i) active_q <= 1'b1;

      if (gnt_take) begin
        req_q         <= 1'b0;   // one in flight, drop req
        outstanding_q <= 1'b1;
      end else if (resp_done) begin
        outstanding_q <= 1'b0;
      end
      if (issue) req_q <= 1'b1;  // never together with gnt_take

      // a flush marks whatever is on the bus as stale
      if (branch_i) discard_q <= (req_q | outstanding_q) & ~resp_done;
      else if (resp_done) discard_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) addr_q <= issue_addr;
    if (branch_i) begin
      next_addr_q <= addr_i;
    end else if (gnt_take & ~discard_q) begin
      next_addr_q <= addr_q + ibus_pkg::WORD_BYTES;  // stale grant keeps branch target
    end
  end

  assign ibus_req_o.req  = req_q;
  assign ibus_req_o.addr = addr_q;
  assign busy_o          = req_q | outstanding_q;

  // ----------------------------------------------------------------------
  // word fifo
  // ----------------------------------------------------------------------
  assign fifo_wr = resp_done & ~discard_q & ~branch_i;
  assign fifo_rd = ready_i & valid_o & ~branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (branch_i) begin
      wr_ptr_q <= '0;  // flush
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo_wr) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (fifo_rd) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({fifo_wr, fifo_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // response address is still in addr_q at the edge it arrives
  always_ff @(posedge clk) begin
    if (fifo_wr) fifo_mem[wr_ptr_q] <= '{addr: addr_q, data: ibus_rsp_i.rdata};
  end

  assign valid_o = (count_q != '0);
  assign rdata_o = fifo_mem[rd_ptr_q].data;
  assign addr_o  = fifo_mem[rd_ptr_q].addr;

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------
  // memory side must only grant a raised request
  assert property (@(posedge clk) disable iff (!rst_n)
    ibus_rsp_i.gnt |-> ibus_req_o.req)
    else $error("ibus grant without a request");

  // redirect targets from the pc selector must land on word boundaries
  assert property (@(posedge clk) disable iff (!rst_n)
    ibus_req_o.req |-> (ibus_req_o.addr[1:0] == 2'b00))
    else $error("ibus request address not word-aligned");

endmodule

/* if_issue_ctrl.sv */
// ----------------------------------------------------------------------
// offset fsm, issue decision and if/id register
// a redirect cycle never issues, the record freezes while id stalls
// clear_instr_valid_i drops only the valid bit
// ----------------------------------------------------------------------
module if_issue_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic                pc_set_i,
  input  logic                fetch_valid_i,
  input  logic [31:0]         fetch_rdata_i,
  input  logic [31:0]         fetch_addr_i,
  input  logic                halt_if_i,
  input  logic                id_ready_i,
  input  logic                clear_instr_valid_i,
  output logic                fetch_ready_o,
  output logic                branch_req_o,
  output if_ctrl_pkg::if_id_t id_o
);

  typedef enum logic [0:0] {
    IDLE = 1'b0,  // nothing requested yet
    WAIT = 1'b1   // serving words from prefetch
  } fsm_e;

  fsm_e        state_q, state_n;
  logic        valid;     // word available for id
  logic        if_ready;  // id can take it
  logic        if_valid;  // word moves into if/id this cycle

  logic        valid_q;
  logic [31:0] instr_q;
  logic [31:0] pc_q;

  // ----------------------------------------------------------------------
  // offset fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_n;
  end

  always_comb begin
    state_n      = state_q;
    branch_req_o = 1'b0;
    valid        = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          branch_req_o = 1'b1;  // first fetch from current fetch address
          state_n      = WAIT;
        end
      end
      WAIT: begin
        valid = fetch_valid_i;  // aligned word only
      end
      default: state_n = IDLE;
    endcase

    // redirect wins, current head is stale
    if (pc_set_i) begin
      valid        = 1'b0;
      branch_req_o = 1'b1;
      state_n      = WAIT;
    end
  end

  assign if_ready      = valid & id_ready_i;
  assign if_valid      = if_ready & ~halt_if_i;
  assign fetch_ready_o = if_valid;  // pop head as it loads

  // ----------------------------------------------------------------------
  // if/id register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (if_valid) begin
      valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      valid_q <= 1'b0;  // load takes priority over clear
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      instr_q <= fetch_rdata_i;
      pc_q    <= fetch_addr_i;
    end
  end

  assign id_o = '{valid: valid_q, instr: instr_q, pc: pc_q};

  // prefetch head stays put until it is popped or flushed
  assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_valid_i && !fetch_ready_o && !branch_req_o) |=>
      (fetch_valid_i && $stable(fetch_addr_i) && $stable(fetch_rdata_i)))
    else $error("prefetch head changed before it was taken");

endmodule

/* if_stage.sv */
// ----------------------------------------------------------------------
// instruction fetch stage top, 32-bit word fetch only
// redirect_i.pc_set is a one-cycle strobe from the controller
// no compressed support, no hardware loops, no fetch error path
// ----------------------------------------------------------------------
module if_stage #(
  parameter logic [31:0] DM_HALT_ADDR = 32'h1A11_0800,
  parameter logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808,
  parameter int          FIFO_DEPTH   = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [23:0]            boot_addr_i,
  input  logic [23:0]            trap_base_i,
  input  logic                   req_i,
  input  if_ctrl_pkg::redirect_t redirect_i,
  input  logic [31:0]            jump_target_id_i,
  input  logic [31:0]            jump_target_ex_i,
  input  logic [31:0]            mepc_i,
  input  logic [31:0]            depc_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  input  ibus_pkg::ibus_rsp_t    ibus_rsp_i,
  output ibus_pkg::ibus_req_t    ibus_req_o,
  output if_ctrl_pkg::if_id_t    id_o,
  output logic [31:0]            pc_if_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  logic [31:0] fetch_addr_n;   // redirect target, aligned
  logic        branch_req;
  logic        fetch_valid, fetch_ready;
  logic [31:0] fetch_rdata, fetch_addr;
  logic        prefetch_busy;

  if_pc_select #(
    .DM_HALT_ADDR (DM_HALT_ADDR),
    .DM_EXC_ADDR  (DM_EXC_ADDR)
  ) pc_select_i (
    .boot_addr_i      (boot_addr_i),
    .trap_base_i      (trap_base_i),
    .redirect_i       (redirect_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .mepc_i           (mepc_i),
    .depc_i           (depc_i),
    .pc_id_i          (id_o.pc),       // fence.i restarts after this one
    .fetch_addr_o     (fetch_addr_n)
  );

  if_prefetch #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .branch_i   (branch_req),
    .addr_i     (fetch_addr_n),
    .ready_i    (fetch_ready),
    .valid_o    (fetch_valid),
    .rdata_o    (fetch_rdata),
    .addr_o     (fetch_addr),
    .busy_o     (prefetch_busy),
    .ibus_req_o (ibus_req_o),
    .ibus_rsp_i (ibus_rsp_i)
  );

  if_issue_ctrl issue_ctrl_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (redirect_i.pc_set),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .fetch_ready_o       (fetch_ready),
    .branch_req_o        (branch_req),
    .id_o                (id_o)
  );

  // status
  assign pc_if_o      = fetch_addr;                  // head of prefetch fifo
  assign if_busy_o    = prefetch_busy;
  assign perf_imiss_o = ~fetch_valid | branch_req;   // nothing to issue or restarting

endmodule

/* tb_imem.sv */
// ----------------------------------------------------------------------
// instruction memory model for the fetch stage testbench
// every word reads as its own address xor MEM_XOR, read only
// grant 0..2 cycles after req, rvalid 1..3 cycles after the grant
// delays are taken from the random word on rnd_i
// ----------------------------------------------------------------------
module tb_imem #(
  parameter logic [31:0] MEM_XOR = 32'h0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         rnd_i,       // fresh random word every cycle
  input  ibus_pkg::ibus_req_t ibus_req_i,
  output ibus_pkg::ibus_rsp_t ibus_rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        gnt_q, rvalid_q;
  logic        pend_q;          // granted, response not yet sent
  logic [31:0] rdata_q, pend_addr_q;
  logic [1:0]  gnt_wait_q;      // cycles left before the next grant
  logic [1:0]  rsp_wait_q;      // cycles left before rvalid

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q       <= 1'b0;
      rvalid_q    <= 1'b0;
      pend_q      <= 1'b0;
      rdata_q     <= '0;
      pend_addr_q <= '0;
      gnt_wait_q  <= 2'd0;
      rsp_wait_q  <= 2'd0;
    end else begin
      gnt_q    <= 1'b0;  // both are one-cycle strobes
      rvalid_q <= 1'b0;
      if (ibus_req_i.req && !gnt_q) begin
        if (gnt_wait_q == 2'd0) gnt_q <= 1'b1;
        else                    gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      // request taken at this edge, latch address and pick new delays
      if (gnt_q && ibus_req_i.req) begin
        pend_q      <= 1'b1;
        pend_addr_q <= ibus_req_i.addr;
        rsp_wait_q  <= 2'(rnd_i[9:8] % 2'd3);
        gnt_wait_q  <= 2'(rnd_i[1:0] % 2'd3);
      end
      if (pend_q) begin
        if (rsp_wait_q == 2'd0) begin
          rvalid_q <= 1'b1;
          rdata_q  <= pend_addr_q ^ MEM_XOR;  // address pattern
          pend_q   <= 1'b0;
        end else begin
          rsp_wait_q <= rsp_wait_q - 2'd1;
        end
      end
    end
  end

  assign ibus_rsp_o = '{gnt: gnt_q, rvalid: rvalid_q, rdata: rdata_q};

endmodule

/* tb_if_stage.sv */
// ----------------------------------------------------------------------
// testbench for the fetch stage, word fetch from a pattern memory
// redirect targets sit far apart so each new record changes pc
// a fixed sequence runs, every wait is bounded by WAIT_MAX cycles
// ----------------------------------------------------------------------
module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [23:0] BOOT_ADDR    = 24'h00_0010;   // first pc 0x1080
  localparam logic [23:0] TRAP_BASE    = 24'h00_0200;
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0C00;  // away from the halt stream
  localparam logic [31:0] MEM_XOR      = 32'hA5C3_0F96;
  localparam int          WAIT_MAX     = 200;

  logic                   clk = 1'b0;
  logic                   rst_n, req, halt_if, id_ready, clear_valid;
  logic [31:0]            jump_id, jump_ex, mepc, depc, pc_if;
  logic                   if_busy, imiss;
  if_ctrl_pkg::redirect_t redirect;
  if_ctrl_pkg::if_id_t    id;
  if_ctrl_pkg::if_id_t    prev_id = '0;        // record seen at the last edge
  ibus_pkg::ibus_req_t    ibus_req;
  ibus_pkg::ibus_rsp_t    ibus_rsp;

  logic [31:0] rnd_q      = 32'd88;
  logic [1:0]  stall_mode = 2'd0;              // 0 none, 1 random, 2 id held
  logic [31:0] exp_pc     = {BOOT_ADDR, 8'h80};
  logic        stall_q    = 1'b0;
  logic        clear_q    = 1'b0;
  logic [31:0] prev_pc_if = '0;                // fifo head pc at the last edge
  logic        prev_imiss = 1'b1;
  logic        bus_out_q  = 1'b0;              // granted, rvalid not seen yet
  int          n_loads    = 0;
  int          mismatches = 0;
  int          other_errs = 0;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_XOR;
  endfunction

  // expected first pc after a redirect
  function automatic logic [31:0] redirect_target(input if_ctrl_pkg::redirect_t r,
                                                  input logic [31:0] pc_id);
    logic [31:0] t;
    case (r.pc_mux)
      if_ctrl_pkg::PC_JUMP:   t = jump_id;
      if_ctrl_pkg::PC_BRANCH: t = jump_ex;
      if_ctrl_pkg::PC_MRET:   t = mepc;
      if_ctrl_pkg::PC_DRET:   t = depc;
      if_ctrl_pkg::PC_FENCEI: t = pc_id + 32'd4;
      if_ctrl_pkg::PC_EXCEPTION: begin
        case (r.exc_pc_mux)
          if_ctrl_pkg::EXC_PC_IRQ: t = {TRAP_BASE, 8'h00} + {25'd0, r.exc_vec, 2'b00};
          if_ctrl_pkg::EXC_PC_DBD: t = DM_HALT_ADDR;
          if_ctrl_pkg::EXC_PC_DBE: t = DM_EXC_ADDR;
          default:                 t = {TRAP_BASE, 8'h00};
        endcase
      end
      default: t = {BOOT_ADDR, 8'h80};
    endcase
    return t & 32'hFFFF_FFFC;  // word fetch
  endfunction

  tb_imem #(.MEM_XOR(MEM_XOR)) imem_i (
    .clk (clk), .rst_n (rst_n), .rnd_i (rnd_q), .ibus_req_i (ibus_req), .ibus_rsp_o (ibus_rsp)
  );

  if_stage #(
    .DM_HALT_ADDR (DM_HALT_ADDR),
    .DM_EXC_ADDR  (DM_EXC_ADDR),
    .FIFO_DEPTH   (2)
  ) if_stage_i (
    .clk (clk), .rst_n (rst_n), .boot_addr_i (BOOT_ADDR), .trap_base_i (TRAP_BASE),
    .req_i (req), .redirect_i (redirect), .jump_target_id_i (jump_id),
    .jump_target_ex_i (jump_ex), .mepc_i (mepc), .depc_i (depc), .halt_if_i (halt_if),
    .id_ready_i (id_ready), .clear_instr_valid_i (clear_valid), .ibus_rsp_i (ibus_rsp),
    .ibus_req_o (ibus_req), .id_o (id), .pc_if_o (pc_if), .if_busy_o (if_busy),
    .perf_imiss_o (imiss)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // random source and id stall generator
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    rnd_q <= xorshift(rnd_q);
    case (stall_mode)
      2'd1: begin
        id_ready <= (rnd_q[3:2] != 2'b00);  // roughly one cycle in four
        halt_if  <= (rnd_q[6:4] == 3'b000);
      end
      2'd2: begin
        id_ready <= 1'b0;
        halt_if  <= 1'b0;
      end
      default: begin
        id_ready <= 1'b1;
        halt_if  <= 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // checker, sees at each edge what the previous edge loaded
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (id.valid && (!prev_id.valid || id.pc != prev_id.pc)) begin  // new record
        n_loads <= n_loads + 1;
        if (id.pc !== exp_pc || id.instr !== mem_word(exp_pc)) begin
          $display("Mismatch at %0t: record pc %h instr %h, expected pc %h instr %h",
                   $time, id.pc, id.instr, exp_pc, mem_word(exp_pc));
          mismatches++;
        end
        // in the load cycle the fifo head held this pc and no miss was flagged
        if (prev_pc_if !== exp_pc || prev_imiss !== 1'b0) begin
          $display("Mismatch at %0t: load cycle pc_if %h imiss %b, expected pc_if %h imiss 0",
                   $time, prev_pc_if, prev_imiss, exp_pc);
          mismatches++;
        end
        exp_pc = exp_pc + 32'd4;
      end
      if (stall_q && prev_id.valid && (id.pc !== prev_id.pc || id.instr !== prev_id.instr)) begin
        $display("Mismatch at %0t: record changed during stall, pc %h", $time, id.pc);
        mismatches++;
      end
      if (clear_q && stall_q && id.valid) begin
        $display("Mismatch at %0t: valid still set after clear", $time);
        mismatches++;
      end
      if (redirect.pc_set && imiss !== 1'b1) begin
        $display("Mismatch at %0t: imiss low in a redirect cycle", $time);
        mismatches++;
      end
      if (if_busy !== (ibus_req.req | bus_out_q)) begin  // request raised or in flight
        $display("Mismatch at %0t: busy %b, expected %b",
                 $time, if_busy, ibus_req.req | bus_out_q);
        mismatches++;
      end
      if (redirect.pc_set) exp_pc = redirect_target(redirect, id.pc);  // taken at this edge
    end
    if (ibus_req.req && ibus_rsp.gnt) bus_out_q = 1'b1;
    else if (ibus_rsp.rvalid)        bus_out_q = 1'b0;
    prev_id    = id;
    prev_pc_if = pc_if;
    prev_imiss = imiss;
    stall_q    = !id_ready || halt_if;
    clear_q    = clear_valid;
  end

  task automatic wait_loads(input int n, input string what);
    int target;
    int waited;
    target = n_loads + n;
    waited = 0;
    while (n_loads < target && waited < WAIT_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (n_loads < target) begin
      $display("Timeout after %0d cycles waiting for %s", WAIT_MAX, what);
      other_errs++;
    end
  endtask

  task automatic take_redirect(input if_ctrl_pkg::pc_mux_e m,
                               input if_ctrl_pkg::exc_pc_mux_e e, input logic [4:0] v);
    @(posedge clk);
    redirect <= '{pc_set: 1'b1, pc_mux: m, exc_pc_mux: e, exc_vec: v};
    @(posedge clk);
    redirect.pc_set <= 1'b0;
    wait_loads(3, "records after a redirect");
  endtask

  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    redirect    = '{pc_set: 1'b0, pc_mux: if_ctrl_pkg::PC_BOOT,
                    exc_pc_mux: if_ctrl_pkg::EXC_PC_EXCEPTION, exc_vec: 5'd0};
    jump_id     = 32'h0000_4000;
    jump_ex     = 32'h0000_5100;
    mepc        = 32'h0000_6204;
    depc        = 32'h0000_7308;
    halt_if     = 1'b0;
    id_ready    = 1'b1;
    clear_valid = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    req <= 1'b1;
    wait_loads(4, "first records after boot");
    stall_mode <= 2'd1;
    wait_loads(12, "records under random stalls");
    take_redirect(if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    take_redirect(if_ctrl_pkg::PC_BRANCH, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    take_redirect(if_ctrl_pkg::PC_MRET, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    take_redirect(if_ctrl_pkg::PC_DRET, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    take_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    // upper lines only, keeps the vector clear of the exception stream
    take_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_IRQ, {1'b1, rnd_q[3:0]});
    take_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_DBD, 5'd0);
    take_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_DBE, 5'd0);
    take_redirect(if_ctrl_pkg::PC_FENCEI, if_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    // hold id, then clear the held record
    stall_mode <= 2'd2;
    repeat (3) @(posedge clk);
    clear_valid <= 1'b1;
    @(posedge clk);
    clear_valid <= 1'b0;
    repeat (2) @(posedge clk);
    stall_mode <= 2'd0;
    wait_loads(3, "records after clear");
    @(negedge clk);
    $display("mismatches %0d, other errors %0d", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
ibus_pkg.sv
if_ctrl_pkg.sv
if_pc_select.sv
if_prefetch.sv
if_issue_ctrl.sv
if_stage.sv
tb_imem.sv
tb_if_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_if_stage
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# the run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
